// ==== source/rvPkg.sv ====
// Shared definitions for the RV32I multi-cycle core
// Widths, reset address, major opcode codes and the one-hot FSM encoding
// Imported by every module of the core
package rvPkg;

   // Data path and address widths
   localparam int xlen      = 32;
   localparam int addrWidth = 24;

   // Basic payload types
   typedef logic [xlen-1:0]      wordT;
   typedef logic [addrWidth-1:0] addrT;
   typedef logic [4:0]           regIdT;

   // PC value after reset
   localparam addrT resetAddr = '0;

   // Major opcodes, instruction bits 6:2
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;

   // One-hot FSM states
   // waitMem also serves as the idle state after reset
   typedef enum logic [3:0] {
      fetchInstr = 4'b0001,
      waitInstr  = 4'b0010,
      execute    = 4'b0100,
      waitMem    = 4'b1000
   } stateT;

endpackage

// ==== source/rvDecoder.sv ====
// Instruction register and decoder of the RV32I core
// Latches the fetched word on instrLoad, then decodes it combinationally
// into class flags, funct3 and the five immediate formats
`timescale 1ns/10ps

module rvDecoder (
   input  logic         clk,
   input  logic         instrLoad,
   input  rvPkg::wordT  memRdata,
   output logic         isLoad,
   output logic         isAluImm,
   output logic         isAluReg,
   output logic         isAuipc,
   output logic         isStore,
   output logic         isLui,
   output logic         isBranch,
   output logic         isJalr,
   output logic         isJal,
   output rvPkg::regIdT rdId,
   output logic [2:0]   funct3,
   output logic         instrBit30,
   output logic         instrBit5,
   output rvPkg::wordT  iImm,
   output rvPkg::wordT  sImm,
   output rvPkg::wordT  bImm,
   output rvPkg::wordT  jImm,
   output rvPkg::wordT  uImm
);
   import rvPkg::*;

   // Bits 1:0 are always 11 in RV32I, so they are not kept
   logic [31:2] instr;
   logic [4:0]  opcode;

   always_ff @(posedge clk) begin
      if (instrLoad) begin
         instr <= memRdata[31:2];
      end
   end

   assign opcode = instr[6:2];

   // One flag per instruction class
   // SYSTEM and unknown opcodes raise none of them
   assign isLoad   = (opcode == opLoad);
   assign isAluImm = (opcode == opAluImm);
   assign isAuipc  = (opcode == opAuipc);
   assign isStore  = (opcode == opStore);
   assign isAluReg = (opcode == opAluReg);
   assign isLui    = (opcode == opLui);
   assign isBranch = (opcode == opBranch);
   assign isJalr   = (opcode == opJalr);
   assign isJal    = (opcode == opJal);

   // Fixed fields
   assign rdId       = instr[11:7];
   assign funct3     = instr[14:12];
   // Bit 30 picks SUB and SRA, bit 5 tells register ops from immediate ops
   assign instrBit30 = instr[30];
   assign instrBit5  = instr[5];

   // Immediates, all sign-extended from bit 31
   assign uImm = {instr[31:12], 12'b0};
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

// ==== source/rvRegFile.sv ====
// 32 x 32-bit register file with registered reads
// Both sources are captured when the instruction word arrives
// Register zero always reads as zero
`timescale 1ns/10ps

module rvRegFile (
   input  logic         clk,
   input  logic         readEnable,
   input  rvPkg::regIdT rs1Id,
   input  rvPkg::regIdT rs2Id,
   input  logic         writeEnable,
   input  rvPkg::regIdT rdId,
   input  rvPkg::wordT  writeData,
   output rvPkg::wordT  rs1,
   output rvPkg::wordT  rs2
);
   import rvPkg::*;

   wordT regs [32];

   // Write port, index zero is never written
   always_ff @(posedge clk) begin
      if (writeEnable && (rdId != 5'd0)) begin
         regs[rdId] <= writeData;
      end
   end

   // Read ports
   // Index zero is forced to zero, so x0 needs no initial value
   always_ff @(posedge clk) begin
      if (readEnable) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

endmodule

// ==== source/rvAlu.sv ====
// Combinational ALU of the RV32I core
// Adder, one 33-bit subtractor for all compares, a single right shifter
// shared with left shifts by bit reversal, logic ops and branch predicate
`timescale 1ns/10ps

module rvAlu (
   input  rvPkg::wordT rs1,
   input  rvPkg::wordT rs2,
   input  rvPkg::wordT iImm,
   input  logic        useRs2,
   input  logic [2:0]  funct3,
   input  logic        instrBit30,
   input  logic        instrBit5,
   input  logic        isBranch,
   output rvPkg::wordT aluOut,
   output rvPkg::wordT aluPlus,
   output logic        predicate
);
   import rvPkg::*;

   wordT               op2;
   logic [7:0]         funct3Is;
   logic [32:0]        aluMinus;
   logic               lt;
   logic               ltu;
   logic               eq;
   wordT               shiftIn;
   logic signed [32:0] shiftExt;
   logic signed [32:0] shiftRes;
   wordT               shiftRight;
   wordT               shiftLeft;

   function automatic wordT reverseBits(input wordT value);
      wordT result;
      for (int i = 0; i < xlen; i++) begin
         result[i] = value[xlen-1-i];
      end
      return result;
   endfunction

   // Second operand: rs2 for register ops and branches, else I-immediate
   assign op2      = useRs2 ? rs2 : iImm;
   // funct3 in one-hot form
   assign funct3Is = 8'b0000_0001 << funct3;

   // Also feeds JALR target and nothing else needs a second adder
   assign aluPlus = rs1 + op2;

   // rs1 - op2 with the borrow in bit 32
   assign aluMinus = {1'b1, ~op2} + {1'b0, rs1} + 33'd1;
   // Signed compare falls back to the borrow when signs agree
   assign lt  = (rs1[31] ^ op2[31]) ? rs1[31] : aluMinus[32];
   assign ltu = aluMinus[32];
   assign eq  = (aluMinus[31:0] == '0);

   // Left shifts run through the right shifter on reversed data
   assign shiftIn    = funct3Is[1] ? reverseBits(rs1) : rs1;
   // Extra top bit carries the sign for SRA only
   assign shiftExt   = {instrBit30 & rs1[31], shiftIn};
   assign shiftRes   = shiftExt >>> op2[4:0];
   assign shiftRight = shiftRes[31:0];
   assign shiftLeft  = reverseBits(shiftRight);

   always_comb begin
      case (funct3)
         // SUB only for register ops, ADDI reuses bit 30 as immediate
         3'd0: aluOut = (instrBit30 & instrBit5) ? aluMinus[31:0] : aluPlus;
         3'd1: aluOut = shiftLeft;
         3'd2: aluOut = {31'b0, lt};
         3'd3: aluOut = {31'b0, ltu};
         3'd4: aluOut = rs1 ^ op2;
         3'd5: aluOut = shiftRight;
         3'd6: aluOut = rs1 | op2;
         default: aluOut = rs1 & op2;
      endcase
   end

   // Branch condition, codes 2 and 3 are unused
   assign predicate = isBranch & (
      (funct3Is[0] &  eq)  |
      (funct3Is[1] & ~eq)  |
      (funct3Is[4] &  lt)  |
      (funct3Is[5] & ~lt)  |
      (funct3Is[6] &  ltu) |
      (funct3Is[7] & ~ltu));

endmodule

// ==== source/rvLoadStore.sv ====
// Load/store data path of the RV32I core
// Forms the access address, steers store bytes onto their lanes with a
// matching write mask, and extracts and extends load data
`timescale 1ns/10ps

module rvLoadStore (
   input  rvPkg::wordT rs1,
   input  rvPkg::wordT rs2,
   input  rvPkg::wordT iImm,
   input  rvPkg::wordT sImm,
   input  logic        isStore,
   input  logic [2:0]  funct3,
   input  rvPkg::wordT memRdata,
   output rvPkg::addrT lsAddr,
   output rvPkg::wordT memWdata,
   output logic [3:0]  storeMask,
   output rvPkg::wordT loadData
);
   import rvPkg::*;

   wordT        offset;
   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // Address adder, only addrWidth bits are kept
   assign offset = isStore ? sImm : iImm;
   assign lsAddr = rs1[addrWidth-1:0] + offset[addrWidth-1:0];

   // funct3[1:0]: 00 byte, 01 halfword, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // Store data replicated so the addressed lanes carry the right bytes
   assign memWdata[7:0]   = rs2[7:0];
   assign memWdata[15:8]  = lsAddr[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = lsAddr[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = lsAddr[0] ? rs2[7:0] :
                            lsAddr[1] ? rs2[15:8] : rs2[31:24];

   // Byte enables from size and low address bits
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   // Select halfword, then byte within it
   assign loadHalf = lsAddr[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means LBU or LHU
   assign loadSign = ~funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  memRdata;

endmodule

// ==== source/rvControl.sv ====
// Control unit of the RV32I core
// One-hot fetch/execute/wait FSM, program counter and next-PC logic,
// register write-back selection and the memory bus strobes
`timescale 1ns/10ps

module rvControl (
   input  logic        clk,
   input  logic        reset,
   input  logic        memRbusy,
   input  logic        memWbusy,
   input  logic        isLoad,
   input  logic        isAluImm,
   input  logic        isAluReg,
   input  logic        isAuipc,
   input  logic        isStore,
   input  logic        isLui,
   input  logic        isBranch,
   input  logic        isJalr,
   input  logic        isJal,
   input  rvPkg::wordT uImm,
   input  rvPkg::wordT bImm,
   input  rvPkg::wordT jImm,
   input  rvPkg::wordT aluOut,
   input  rvPkg::wordT aluPlus,
   input  rvPkg::wordT loadData,
   input  logic        predicate,
   input  rvPkg::addrT lsAddr,
   input  logic [3:0]  storeMask,
   output logic        instrLoad,
   output logic        regWrite,
   output rvPkg::wordT writeBackData,
   output rvPkg::wordT memAddr,
   output logic        memRstrb,
   output logic [3:0]  memWmask
);
   import rvPkg::*;

   stateT state;
   addrT  pc;
   addrT  pcPlus4;
   wordT  pcWide;
   wordT  pcImm;
   wordT  pcPlusImm;
   addrT  pcNext;
   logic  isAlu;
   logic  needWait;

   assign isAlu    = isAluImm | isAluReg;
   assign needWait = isLoad | isStore;

   // PC arithmetic; PC+imm is kept at 32 bits for AUIPC
   assign pcPlus4   = pc + addrT'(4);
   assign pcWide    = {{(xlen-addrWidth){1'b0}}, pc};
   assign pcImm     = isJal ? jImm : isAuipc ? uImm : bImm;
   assign pcPlusImm = pcWide + pcImm;

   // JALR target has bit 0 cleared
   always_comb begin
      if (isJalr) begin
         pcNext = {aluPlus[addrWidth-1:1], 1'b0};
      end else if (isJal || (isBranch && predicate)) begin
         pcNext = pcPlusImm[addrWidth-1:0];
      end else begin
         pcNext = pcPlus4;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Wait for the bus to go idle before the first fetch
         state <= waitMem;
         pc    <= resetAddr;
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               pc    <= pcNext;
               state <= needWait ? waitMem : fetchInstr;
            end
            waitMem: begin
               if (!memRbusy && !memWbusy) begin
                  state <= fetchInstr;
               end
            end
            default: state <= waitMem;
         endcase
      end
   end

   // Instruction word valid on the bus
   assign instrLoad = (state == waitInstr) & ~memRbusy;

   // Loads write back from waitMem once read data is valid
   // SYSTEM falls through all classes and writes nothing
   assign regWrite =
      ((state == execute) & (isAlu | isLui | isAuipc | isJal | isJalr)) |
      ((state == waitMem) & isLoad & ~memRbusy);

   always_comb begin
      if (isLoad) begin
         writeBackData = loadData;
      end else if (isLui) begin
         writeBackData = uImm;
      end else if (isAuipc) begin
         writeBackData = pcPlusImm;
      end else if (isJal || isJalr) begin
         writeBackData = {{(xlen-addrWidth){1'b0}}, pcPlus4};
      end else begin
         writeBackData = aluOut;
      end
   end

   // PC during instruction fetch, load/store address otherwise
   assign memAddr = ((state == fetchInstr) || (state == waitInstr)) ?
                    pcWide : {{(xlen-addrWidth){1'b0}}, lsAddr};

   // One-cycle strobes, both only outside waitMem
   assign memRstrb = (state == fetchInstr) | ((state == execute) & isLoad);
   assign memWmask = {4{(state == execute) & isStore}} & storeMask;

endmodule

// ==== source/rvCore.sv ====
// Top level of the multi-cycle RV32I core
// Connects decoder, register file, ALU, load/store path and control
// to a single shared instruction and data memory bus
`timescale 1ns/10ps

module rvCore (
   input  logic        clk,
   input  logic        reset,
   output rvPkg::wordT memAddr,
   output rvPkg::wordT memWdata,
   output logic [3:0]  memWmask,
   output logic        memRstrb,
   input  rvPkg::wordT memRdata,
   input  logic        memRbusy,
   input  logic        memWbusy
);
   import rvPkg::*;

   // Decoder outputs
   logic       isLoad;
   logic       isAluImm;
   logic       isAluReg;
   logic       isAuipc;
   logic       isStore;
   logic       isLui;
   logic       isBranch;
   logic       isJalr;
   logic       isJal;
   regIdT      rdId;
   logic [2:0] funct3;
   logic       instrBit30;
   logic       instrBit5;
   wordT       iImm;
   wordT       sImm;
   wordT       bImm;
   wordT       jImm;
   wordT       uImm;

   // Data path
   wordT       rs1;
   wordT       rs2;
   wordT       aluOut;
   wordT       aluPlus;
   logic       predicate;
   logic       useRs2;
   addrT       lsAddr;
   logic [3:0] storeMask;
   wordT       loadData;

   // Control
   logic       instrLoad;
   logic       regWrite;
   wordT       writeBackData;

   // Branches compare two registers like register ALU ops
   assign useRs2 = isAluReg | isBranch;

   rvDecoder decoder (
      .clk, .instrLoad, .memRdata,
      .isLoad, .isAluImm, .isAluReg, .isAuipc, .isStore,
      .isLui, .isBranch, .isJalr, .isJal,
      .rdId, .funct3, .instrBit30, .instrBit5,
      .iImm, .sImm, .bImm, .jImm, .uImm
   );

   // Source indexes come straight from the bus while the word is latched
   rvRegFile regFile (
      .clk,
      .readEnable (instrLoad),
      .rs1Id      (memRdata[19:15]),
      .rs2Id      (memRdata[24:20]),
      .writeEnable(regWrite),
      .rdId,
      .writeData  (writeBackData),
      .rs1, .rs2
   );

   rvAlu alu (
      .rs1, .rs2, .iImm, .useRs2, .funct3,
      .instrBit30, .instrBit5, .isBranch,
      .aluOut, .aluPlus, .predicate
   );

   rvLoadStore loadStore (
      .rs1, .rs2, .iImm, .sImm, .isStore, .funct3, .memRdata,
      .lsAddr, .memWdata, .storeMask, .loadData
   );

   rvControl control (
      .clk, .reset, .memRbusy, .memWbusy,
      .isLoad, .isAluImm, .isAluReg, .isAuipc, .isStore,
      .isLui, .isBranch, .isJalr, .isJal,
      .uImm, .bImm, .jImm, .aluOut, .aluPlus, .loadData, .predicate,
      .lsAddr, .storeMask,
      .instrLoad, .regWrite, .writeBackData,
      .memAddr, .memRstrb, .memWmask
   );

endmodule

// ==== tests/rvCoreAssert_assert.sv ====
// Concurrent checks on the control FSM and the memory bus strobes
// Bound into every rvControl instance
`timescale 1ns/10ps

module rvCoreAssert (
   input logic         clk,
   input logic         reset,
   input rvPkg::stateT state,
   input logic [3:0]   memWmask,
   input logic         memRstrb,
   input logic         memRbusy,
   input logic         memWbusy,
   input rvPkg::wordT  memAddr
);
   import rvPkg::*;

   // State register never leaves one-hot form
   stateOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot(state))
      else $error("FSM state is not one-hot");

   // Write strobe only in execute
   maskInExecute: assert property (@(posedge clk) disable iff (!reset)
      (memWmask != 4'b0) |-> (state == execute))
      else $error("write mask active outside execute");

   noReadInWaitMem: assert property (@(posedge clk) disable iff (!reset)
      memRstrb |-> (state != waitMem))
      else $error("read strobe high in waitMem");

   // Bus held steady while the memory stalls the core
   stableWhileBusy: assert property (@(posedge clk) disable iff (!reset)
      ((state == waitMem) && (memRbusy || memWbusy)) |=>
      ($stable(memAddr) && $stable(memWmask) && $stable(memRstrb)))
      else $error("bus outputs changed while busy held waitMem");

endmodule

bind rvControl rvCoreAssert checks (
   .clk, .reset, .state, .memWmask, .memRstrb, .memRbusy, .memWbusy, .memAddr
);

// ==== tests/rvCoreTb.sv ====
// Testbench for the RV32I core
// Builds small programs in a word memory, runs them and checks stored results
// against reference functions, with and without bus stalls
`timescale 1ns/10ps

module rvCoreTb;

   localparam int dataBase = 'h400;
   localparam int resBase  = 'h600;
   localparam int doneAddr = 'h7FC;
   // Allows 14 runs of up to 41 instructions with up to 3 stall cycles per access
   localparam int cycleLimit = 14 * (41 * (4 + 2 * 3) + 20) * 2;

   logic        clk;
   logic        reset;
   logic [31:0] memAddr;
   logic [31:0] memWdata;
   logic [3:0]  memWmask;
   logic        memRstrb;
   logic [31:0] memRdata;
   logic        memRbusy;
   logic        memWbusy;

   logic [31:0] mem [512];
   logic [31:0] prog [$];
   logic [31:0] expQ [$];
   logic        reqRd;
   logic [3:0]  reqWr;
   logic [31:0] reqAddr;
   logic [31:0] reqData;
   int          rCount;
   int          wCount;
   logic        stallOn;
   logic        doneSeen;
   int          cycles;
   int          testChecks;
   int          testErrs;
   int          totalChecks;
   int          totalErrs;
   logic [31:0] savedA [3];
   logic [31:0] savedB [3];
   logic [11:0] savedImm [3][9];
   logic [31:0] savedStore;

   rvCore dut (
      .clk, .reset, .memAddr, .memWdata, .memWmask, .memRstrb,
      .memRdata, .memRbusy, .memWbusy
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("timeout: the core did not reach its final store in time");
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // Bus requests sampled mid-cycle where they are stable
   always @(negedge clk) begin
      reqRd   = memRstrb;
      reqWr   = memWmask;
      reqAddr = memAddr;
      reqData = memWdata;
   end

   // Memory model answering a small delay after the edge
   always @(posedge clk) begin
      #1;
      if (!reset) begin
         rCount   = 0;
         wCount   = 0;
         memRbusy = 1'b0;
         memWbusy = 1'b0;
      end else begin
         if (rCount > 0) rCount--;
         if (wCount > 0) wCount--;
         if (reqRd === 1'b1) begin
            memRdata = mem[reqAddr[10:2]];
            rCount   = stallOn ? int'($urandom % 4) : 0;
         end
         if (reqWr != 4'b0) begin
            for (int i = 0; i < 4; i++) begin
               if (reqWr[i]) mem[reqAddr[10:2]][8*i +: 8] = reqData[8*i +: 8];
            end
            if (reqAddr == doneAddr) doneSeen = 1'b1;
            wCount = stallOn ? int'($urandom % 4) : 0;
         end
         memRbusy = (rCount != 0);
         memWbusy = (wCount != 0);
      end
   end

   // Instruction encoders
   function automatic logic [31:0] rFormat(logic alt, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iFormat(logic [11:0] imm, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] sFormat(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
      return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] bFormat(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] jFormat(logic [20:0] imm, logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // Reference ALU result from funct3, the SUB/SRA bit and the operands
   function automatic logic [31:0] aluResult(logic [2:0] f3, logic alt, logic [31:0] a,
                                             logic [31:0] b);
      case (f3)
         3'd0: return alt ? a - b : a + b;
         3'd1: return a << b[4:0];
         3'd2: return {31'b0, $signed(a) < $signed(b)};
         3'd3: return {31'b0, a < b};
         3'd4: return a ^ b;
         3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6: return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   // Load result where funct3 bit 2 selects zero extension
   function automatic logic [31:0] loadResult(logic [2:0] f3, logic [31:0] w, int off);
      logic [7:0]  b;
      logic [15:0] h;
      b = w[8*off +: 8];
      h = w[8*(off & 2) +: 16];
      if (f3[1:0] == 2'b00) return f3[2] ? {24'b0, b} : {{24{b[7]}}, b};
      if (f3[1:0] == 2'b01) return f3[2] ? {16'b0, h} : {{16{h[15]}}, h};
      return w;
   endfunction

   // Memory word after a store of size bytes at a byte offset
   function automatic logic [31:0] mergeLanes(logic [31:0] old, logic [31:0] v, int size,
                                              int off);
      logic [31:0] r;
      r = old;
      for (int i = 0; i < size; i++) r[8*(off+i) +: 8] = v[8*i +: 8];
      return r;
   endfunction

   function automatic logic [31:0] fillWord(int addr);
      return {addr[15:0], ~addr[15:0]} ^ 32'h5A5A_3C3C;
   endfunction

   task automatic check(string name, logic [31:0] exp, logic [31:0] act);
      testChecks++;
      assert (exp === act) else begin
         $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
         testErrs++;
      end
   endtask

   task automatic startTest();
      testChecks = 0;
      testErrs   = 0;
      prog.delete();
      expQ.delete();
   endtask

   task automatic endTest(string name);
      $display("%s: %0d checks, %0d errors", name, testChecks, testErrs);
      totalChecks += testChecks;
      totalErrs   += testErrs;
   endtask

   // Holds reset while the program is loaded, then runs to the final store
   task automatic runProgram();
      @(posedge clk);
      #1 reset = 1'b0;
      doneSeen = 1'b0;
      prog.push_back(sFormat(12'(doneAddr), 5'd0, 3'd2));
      for (int i = 0; i < 256; i++) mem[i] = (i < prog.size()) ? prog[i] : 32'h0;
      repeat (5) @(posedge clk);
      #1 reset = 1'b1;
      while (!doneSeen) @(posedge clk);
      repeat (2) @(posedge clk);
   endtask

   // Result words are left unknown afterwards so a missing store in a later run shows up
   task automatic compareResults(string name);
      foreach (expQ[k]) check(name, expQ[k], mem[(resBase >> 2) + k]);
      for (int k = 0; k < 32; k++) mem[(resBase >> 2) + k] = 'x;
   endtask

   // Ten register ops then nine immediate ops with every result stored
   // Operands and immediates of run r are kept so a stalled rerun is the same program
   task automatic aluProgram(int r);
      logic [31:0] a;
      logic [31:0] b;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm;
      a = savedA[r];
      b = savedB[r];
      mem[dataBase >> 2]       = a;
      mem[(dataBase >> 2) + 1] = b;
      prog.push_back(iFormat(12'(dataBase), 5'd0, 3'd2, 5'd1, 7'b0000011));
      prog.push_back(iFormat(12'(dataBase + 4), 5'd0, 3'd2, 5'd2, 7'b0000011));
      for (int k = 0; k < 19; k++) begin
         f3  = (k < 8) ? 3'(k) : (k == 8) ? 3'd0 : (k == 9) ? 3'd5 :
               (k < 18) ? 3'(k - 10) : 3'd5;
         alt = (k == 8) || (k == 9) || (k == 18);
         if (k < 10) begin
            prog.push_back(rFormat(alt, 5'd2, 5'd1, f3, 5'd3));
            expQ.push_back(aluResult(f3, alt, a, b));
         end else begin
            imm = savedImm[r][k - 10];
            if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'b0, imm[4:0]};
            prog.push_back(iFormat(imm, 5'd1, f3, 5'd3, 7'b0010011));
            expQ.push_back(aluResult(f3, alt && f3 == 3'd5, a, {{20{imm[11]}}, imm}));
         end
         prog.push_back(sFormat(12'(resBase + 4 * k), 5'd3, 3'd2));
      end
   endtask

   // Byte stores at offsets 0..3, halfwords at 0 and 2, then one word
   task automatic storeProgram(logic [31:0] v);
      mem[dataBase >> 2] = v;
      for (int k = 0; k < 7; k++) mem[(resBase >> 2) + k] = fillWord(resBase + 4 * k);
      prog.push_back(iFormat(12'(dataBase), 5'd0, 3'd2, 5'd1, 7'b0000011));
      for (int k = 0; k < 7; k++) begin
         if (k < 4) begin
            prog.push_back(sFormat(12'(resBase + 5 * k), 5'd1, 3'd0));
            expQ.push_back(mergeLanes(fillWord(resBase + 4 * k), v, 1, k));
         end else if (k < 6) begin
            prog.push_back(sFormat(12'(resBase + 6 * k - 8), 5'd1, 3'd1));
            expQ.push_back(mergeLanes(fillWord(resBase + 4 * k), v, 2, 2 * (k - 4)));
         end else begin
            prog.push_back(sFormat(12'(resBase + 24), 5'd1, 3'd2));
            expQ.push_back(v);
         end
      end
   endtask

   initial begin
      logic [31:0] u1;
      logic [31:0] u2;
      logic [31:0] a;
      logic [31:0] b;
      logic [2:0]  f3;
      int          off;
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      stallOn = 1'b0;
      doneSeen = 1'b0;
      cycles = 0;
      totalChecks = 0;
      totalErrs = 0;
      void'($urandom(61));

      startTest();
      for (int r = 0; r < 3; r++) begin
         savedA[r] = $urandom;
         savedB[r] = (r == 0) ? savedA[r] : $urandom;
         for (int i = 0; i < 9; i++) savedImm[r][i] = 12'($urandom);
         expQ.delete();
         prog.delete();
         aluProgram(r);
         runProgram();
         compareResults("alu");
      end
      endTest("alu");

      // Upper immediates and jump links at known addresses
      startTest();
      u1 = {20'($urandom), 12'b0};
      u2 = {20'($urandom), 12'b0};
      prog = '{iFormat(12'd0, 5'd0, 3'd0, 5'd10, 7'b0010011),
               {u1[31:12], 5'd5, 7'b0110111}, {u2[31:12], 5'd6, 7'b0010111},
               jFormat(21'd8, 5'd7), iFormat(12'd1, 5'd10, 3'd0, 5'd10, 7'b0010011),
               iFormat(12'd40, 5'd0, 3'd0, 5'd8, 7'b0010011),
               iFormat(12'd1, 5'd8, 3'd0, 5'd9, 7'b1100111)};
      repeat (3) prog.push_back(iFormat(12'd1, 5'd10, 3'd0, 5'd10, 7'b0010011));
      prog.push_back(sFormat(12'(resBase), 5'd5, 3'd2));
      prog.push_back(sFormat(12'(resBase + 4), 5'd6, 3'd2));
      prog.push_back(sFormat(12'(resBase + 8), 5'd7, 3'd2));
      prog.push_back(sFormat(12'(resBase + 12), 5'd9, 3'd2));
      prog.push_back(sFormat(12'(resBase + 16), 5'd10, 3'd2));
      expQ = '{u1, 32'd8 + u2, 32'd16, 32'd28, 32'd0};
      runProgram();
      compareResults("upper and jumps");
      endTest("upper and jumps");

      // Marker 2 on the taken path, 1 on the fall-through path
      startTest();
      for (int r = 0; r < 3; r++) begin
         a = $urandom;
         b = (r == 0) ? a : (r == 1) ? ~a : $urandom;
         prog.delete();
         expQ.delete();
         mem[dataBase >> 2]       = a;
         mem[(dataBase >> 2) + 1] = b;
         prog.push_back(iFormat(12'(dataBase), 5'd0, 3'd2, 5'd1, 7'b0000011));
         prog.push_back(iFormat(12'(dataBase + 4), 5'd0, 3'd2, 5'd2, 7'b0000011));
         for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            prog.push_back(bFormat(13'd12, 5'd2, 5'd1, f3));
            prog.push_back(iFormat(12'd1, 5'd0, 3'd0, 5'd3, 7'b0010011));
            prog.push_back(jFormat(21'd8, 5'd0));
            prog.push_back(iFormat(12'd2, 5'd0, 3'd0, 5'd3, 7'b0010011));
            prog.push_back(sFormat(12'(resBase + 4 * k), 5'd3, 3'd2));
            expQ.push_back(branchTaken(f3, a, b) ? 32'd2 : 32'd1);
         end
         runProgram();
         compareResults("branch");
      end
      endTest("branch");

      startTest();
      savedStore = $urandom;
      storeProgram(savedStore);
      runProgram();
      compareResults("store lanes");
      endTest("store lanes");

      // LB, LBU at every offset, LH, LHU at both halves
      startTest();
      for (int r = 0; r < 2; r++) begin
         a = (r == 0) ? 32'h80FF_7F01 : $urandom;
         prog.delete();
         expQ.delete();
         mem[dataBase >> 2] = a;
         for (int k = 0; k < 12; k++) begin
            f3  = (k < 4) ? 3'd0 : (k < 8) ? 3'd4 : (k < 10) ? 3'd1 : 3'd5;
            off = (k < 8) ? k % 4 : 2 * (k % 2);
            prog.push_back(iFormat(12'(dataBase + off), 5'd0, f3, 5'd3, 7'b0000011));
            prog.push_back(sFormat(12'(resBase + 4 * k), 5'd3, 3'd2));
            expQ.push_back(loadResult(f3, a, off));
         end
         runProgram();
         compareResults("load extend");
      end
      endTest("load extend");

      // Same programs as the unstalled runs
      startTest();
      stallOn = 1'b1;
      for (int r = 0; r < 3; r++) begin
         prog.delete();
         expQ.delete();
         aluProgram(r);
         runProgram();
         compareResults("stalled alu");
      end
      prog.delete();
      expQ.delete();
      storeProgram(savedStore);
      runProgram();
      compareResults("stalled store");
      stallOn = 1'b0;
      endTest("stalled");

      $display("total: %0d checks, %0d errors", totalChecks, totalErrs);
      if (totalErrs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
source/rvPkg.sv
source/rvDecoder.sv
source/rvRegFile.sv
source/rvAlu.sv
source/rvLoadStore.sv
source/rvControl.sv
source/rvCore.sv
tests/rvCoreAssert_assert.sv
tests/rvCoreTb.sv
